// File: ps2_pkg.sv
// package with PS/2 frame constants, vector typedefs, line and word structs, state enums
package ps2_pkg;

  // ------------------------------
  // frame constants
  // ------------------------------

  // a PS/2 frame is start, eight data bits, parity and stop
  localparam int FRAME_BITS = 11;

  // ------------------------------
  // vector typedefs
  // ------------------------------

  // one scan code from the keyboard or one command byte to it
  typedef logic [7:0] scan_code_t;

  // the whole frame as it sits in the shift register
  typedef logic [FRAME_BITS-1:0] frame_t;

  // the bit counter only needs to reach FRAME_BITS
  typedef logic [3:0] bit_count_t;

  // prefix sent by the keyboard ahead of a key release
  localparam scan_code_t RELEASE_CODE = 8'hF0;

  // ------------------------------
  // packed structs
  // ------------------------------

  // levels seen on the two PS/2 wires
  typedef struct packed {
    logic clk;
    logic data;
  } ps2_line_t;

  // open-drain controls, where 1 lets the pullup win and 0 pulls the wire low
  typedef struct packed {
    logic clk_hi_z;
    logic data_hi_z;
  } ps2_pad_t;

  // word handed to the host, with the release flag from a preceding F0
  typedef struct packed {
    logic       released;
    scan_code_t code;
  } rx_word_t;

  // ------------------------------
  // state enums
  // ------------------------------

  // RX_CLK_H sits at zero so a reset lands on the receive idle state
  typedef enum logic [3:0] {
    RX_CLK_H, RX_CLK_L, RX_FALL_MARK, RX_RISE_MARK,
    TX_RESET_TIMER, TX_FORCE_CLK_L, TX_FIRST_WAIT_CLK_H, TX_WAIT_CLK_H,
    TX_RISE_MARK, TX_CLK_H, TX_CLK_L, TX_WAIT_ACK,
    TX_DONE_RECOVERY, TX_NO_ACK
  } link_state_e;

  // the host side sees a level that holds until it reads the word
  typedef enum logic [0:0] {
    IDLE,
    READY
  } ready_state_e;

endpackage

// File: ps2_timer.sv
// saturating cycle counter with enable clear and a done level
`timescale 1ns/10ps

module ps2_timer #(
  parameter int CYCLES = 2
) (
  input  logic clk,
  input  logic reset,
  input  logic enable_i,
  output logic done_o
);

  // at least one bit even for the degenerate count of one
  localparam int CNT_W = (CYCLES > 1) ? $clog2(CYCLES) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(CYCLES - 1);

  logic [CNT_W-1:0] count;

  // the count falls back to zero one cycle after enable goes away
  always_ff @(posedge clk)
  begin
    if (reset || !enable_i)
      count <= '0;
    else if (count != LAST)
      count <= count + 1'b1;
  end

  // the count holds at its last value, so done stays up while enabled
  assign done_o = enable_i && (count == LAST);

  // done can only appear after the counter has been enabled for a while
  // (this holds for CYCLES of two or more, which the interface always uses)
  a_done_needs_enable: assert property (@(posedge clk) disable iff (reset)
    $rose(done_o) |-> enable_i && $past(enable_i));

endmodule

// File: ps2_link_engine.sv
// PS/2 line engine with synchronizers, line FSM, bit counter, shift register and pad controls
`timescale 1ns/10ps

module ps2_link_engine
  import ps2_pkg::*;
#(
  parameter int TIMER_LONG_CYCLES     = 2950,
  parameter int TIMER_DEBOUNCE_CYCLES = 186
) (
  input  logic       clk,
  input  logic       reset,
  input  ps2_line_t  ps2_line_i,
  input  scan_code_t tx_data_i,
  input  logic       tx_write_i,
  output ps2_pad_t   ps2_pad_o,
  output logic       tx_write_ack_o,
  output logic       tx_error_o,
  output logic       frame_done_o,
  output scan_code_t frame_code_o
);

  ps2_line_t   line_meta;
  ps2_line_t   line_sync;
  link_state_e state;
  link_state_e state_next;
  bit_count_t  bit_count;
  frame_t      shift_q;
  logic        long_enable;
  logic        long_done;
  logic        debounce_enable;
  logic        debounce_done;
  logic        tx_shift_done;
  logic        shift_mark;
  logic        watchdog_clear;

  // ------------------------------
  // input synchronizers
  // ------------------------------

  // two flops per wire, since the keyboard lines are asynchronous and slow edged
  always_ff @(posedge clk)
  begin
    line_meta <= ps2_line_i;
    line_sync <= line_meta;
  end

  // ------------------------------
  // timers
  // ------------------------------

  // long timer forces the request, and doubles as the receive watchdog
  ps2_timer #(
    .CYCLES (TIMER_LONG_CYCLES)
  ) u_long_timer (
    .clk      (clk),
    .reset    (reset),
    .enable_i (long_enable),
    .done_o   (long_done)
  );

  // short timer filters bounce on the clock while transmitting
  ps2_timer #(
    .CYCLES (TIMER_DEBOUNCE_CYCLES)
  ) u_debounce_timer (
    .clk      (clk),
    .reset    (reset),
    .enable_i (debounce_enable),
    .done_o   (debounce_done)
  );

  // ------------------------------
  // line state machine
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= RX_CLK_H;
    else
      state <= state_next;
  end

  always_comb
  begin
    // both wires released and both timers idle unless a state says otherwise
    state_next           = state;
    ps2_pad_o.clk_hi_z   = 1'b1;
    ps2_pad_o.data_hi_z  = 1'b1;
    long_enable          = 1'b0;
    debounce_enable      = 1'b0;
    case (state)
      RX_CLK_H:
      begin
        long_enable = 1'b1;
        if (tx_write_i)
          state_next = TX_RESET_TIMER;
        else if (!line_sync.clk)
          state_next = RX_FALL_MARK;
      end
      RX_CLK_L:
      begin
        long_enable = 1'b1;
        if (tx_write_i)
          state_next = TX_RESET_TIMER;
        else if (line_sync.clk)
          state_next = RX_RISE_MARK;
      end
      // markers last one cycle and let the long timer restart
      RX_FALL_MARK:
        state_next = RX_CLK_L;
      RX_RISE_MARK:
        state_next = RX_CLK_H;
      // one idle cycle so the long timer starts the hold from zero
      TX_RESET_TIMER:
        state_next = TX_FORCE_CLK_L;
      TX_FORCE_CLK_L:
      begin
        // holding the clock low tells the keyboard that the host wants to send
        long_enable        = 1'b1;
        ps2_pad_o.clk_hi_z = 1'b0;
        if (long_done)
          state_next = TX_FIRST_WAIT_CLK_H;
      end
      TX_FIRST_WAIT_CLK_H:
      begin
        // start bit goes out while we wait for the keyboard to clock
        debounce_enable     = 1'b1;
        ps2_pad_o.data_hi_z = 1'b0;
        if (!line_sync.clk && debounce_done)
          state_next = TX_CLK_L;
      end
      TX_WAIT_CLK_H:
      begin
        debounce_enable     = 1'b1;
        ps2_pad_o.data_hi_z = shift_q[0];
        if (line_sync.clk && debounce_done)
          state_next = TX_RISE_MARK;
      end
      TX_RISE_MARK:
      begin
        ps2_pad_o.data_hi_z = shift_q[0];
        state_next          = TX_CLK_H;
      end
      TX_CLK_H:
      begin
        ps2_pad_o.data_hi_z = shift_q[0];
        if (tx_shift_done)
          state_next = TX_WAIT_ACK;
        else if (!line_sync.clk)
          state_next = TX_CLK_L;
      end
      TX_CLK_L:
      begin
        ps2_pad_o.data_hi_z = shift_q[0];
        if (line_sync.clk)
          state_next = TX_WAIT_CLK_H;
      end
      TX_WAIT_ACK:
      begin
        // the keyboard acknowledges by holding data low through a clock pulse
        if (!line_sync.clk && !line_sync.data)
          state_next = TX_DONE_RECOVERY;
        else if (!line_sync.clk && line_sync.data)
          state_next = TX_NO_ACK;
      end
      TX_DONE_RECOVERY, TX_NO_ACK:
      begin
        if (line_sync.clk && line_sync.data)
          state_next = RX_CLK_H;
      end
      default:
        state_next = RX_CLK_H;
    endcase
  end

  // ------------------------------
  // bit counter and shift register
  // ------------------------------

  assign tx_write_ack_o = tx_write_i && ((state == RX_CLK_H) || (state == RX_CLK_L));
  assign tx_error_o     = (state == TX_NO_ACK);

  assign shift_mark     = (state == RX_FALL_MARK) || (state == TX_RISE_MARK);
  assign frame_done_o   = (bit_count == bit_count_t'(FRAME_BITS));
  // the keyboard supplies the acknowledge itself, so transmit stops one bit short
  assign tx_shift_done  = (bit_count == bit_count_t'(FRAME_BITS - 1));
  // a quiet bus with the clock high means any partial frame was abandoned
  assign watchdog_clear = long_done && (state == RX_CLK_H) && line_sync.clk;

  // a write clears the count too, so a receive it cuts off leaves nothing behind
  always_ff @(posedge clk)
  begin
    if (reset || frame_done_o || (state == TX_WAIT_ACK) || tx_write_ack_o || watchdog_clear)
      bit_count <= '0;
    else if (shift_mark)
      bit_count <= bit_count + bit_count_t'(1);
  end

  // frame goes out LSB first as start, data, odd parity, stop
  always_ff @(posedge clk)
  begin
    if (tx_write_ack_o)
      shift_q <= {1'b1, ~^tx_data_i, tx_data_i, 1'b0};
    else if (shift_mark)
      shift_q <= {line_sync.data, shift_q[FRAME_BITS-1:1]};
  end

  assign frame_code_o = shift_q[8:1];

  // ------------------------------
  // assertions
  // ------------------------------

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    bit_count <= bit_count_t'(FRAME_BITS));

  // the clock is only ever pulled low right after the timer reset cycle of a write
  a_clk_pull: assert property (@(posedge clk) disable iff (reset)
    $fell(ps2_pad_o.clk_hi_z) |-> (state == TX_FORCE_CLK_L) && $past(state == TX_RESET_TIMER));

  // an accepted write comes from receive idle and starts the transmit with a clean count
  a_write_ack: assert property (@(posedge clk) disable iff (reset)
    tx_write_ack_o |=> (state == TX_RESET_TIMER) && (bit_count == '0));

endmodule

// File: ps2_rx_decoder.sv
// receive decoder with release-prefix hold, output word register and data-ready FSM
`timescale 1ns/10ps

module ps2_rx_decoder
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       translate_i,
  input  logic       frame_done_i,
  input  scan_code_t frame_code_i,
  input  logic       rx_read_i,
  output rx_word_t   rx_word_o,
  output logic       rx_data_ready_o
);

  ready_state_e state;
  logic         hold_released;
  logic         is_prefix;
  logic         word_strobe;

  // ------------------------------
  // prefix detection
  // ------------------------------

  // with translation off F0 is just another code for the host
  assign is_prefix   = translate_i && (frame_code_i == RELEASE_CODE);
  assign word_strobe = frame_done_i && !is_prefix;

  // the prefix only arms the flag, and the next real code consumes it
  always_ff @(posedge clk)
  begin
    if (reset)
      hold_released <= 1'b0;
    else if (frame_done_i)
      hold_released <= is_prefix;
  end

  // ------------------------------
  // output word
  // ------------------------------

  // a later word simply overwrites one the host has not read yet
  always_ff @(posedge clk)
  begin
    if (reset)
      rx_word_o <= '0;
    else if (word_strobe)
    begin
      rx_word_o.released <= hold_released;
      rx_word_o.code     <= frame_code_i;
    end
  end

  // ------------------------------
  // data-ready state machine
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= IDLE;
    else
    begin
      case (state)
        IDLE:
          if (word_strobe)
            state <= READY;
        READY:
          // a fresh word in the same cycle as the read keeps ready up
          if (rx_read_i && !word_strobe)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  assign rx_data_ready_o = (state == READY);

  // ready is only taken away by a host read
  a_ready_hold: assert property (@(posedge clk) disable iff (reset)
    $fell(rx_data_ready_o) |-> $past(rx_read_i));

endmodule

// File: ps2_keyboard.sv
// top level of the PS/2 keyboard interface joining the link engine and the receive decoder
`timescale 1ns/10ps

module ps2_keyboard
  import ps2_pkg::*;
#(
  // long hold and watchdog length in system clocks
  parameter int TIMER_LONG_CYCLES     = 2950,
  // clock debounce length in system clocks
  parameter int TIMER_DEBOUNCE_CYCLES = 186
) (
  input  logic       clk,
  input  logic       reset,
  // pad side
  input  ps2_line_t  ps2_line_i,
  output ps2_pad_t   ps2_pad_o,
  // host receive side
  input  logic       translate_i,
  input  logic       rx_read_i,
  output rx_word_t   rx_word_o,
  output logic       rx_data_ready_o,
  // host transmit side
  input  scan_code_t tx_data_i,
  input  logic       tx_write_i,
  output logic       tx_write_ack_o,
  output logic       tx_error_o
);

  logic       frame_done;
  scan_code_t frame_code;

  // ------------------------------
  // line engine
  // ------------------------------

  ps2_link_engine #(
    .TIMER_LONG_CYCLES     (TIMER_LONG_CYCLES),
    .TIMER_DEBOUNCE_CYCLES (TIMER_DEBOUNCE_CYCLES)
  ) u_link (
    .clk            (clk),
    .reset          (reset),
    .ps2_line_i     (ps2_line_i),
    .tx_data_i      (tx_data_i),
    .tx_write_i     (tx_write_i),
    .ps2_pad_o      (ps2_pad_o),
    .tx_write_ack_o (tx_write_ack_o),
    .tx_error_o     (tx_error_o),
    .frame_done_o   (frame_done),
    .frame_code_o   (frame_code)
  );

  // ------------------------------
  // receive decoder
  // ------------------------------

  // the decoder decides alone what reaches the host
  ps2_rx_decoder u_rx_decoder (
    .clk             (clk),
    .reset           (reset),
    .translate_i     (translate_i),
    .frame_done_i    (frame_done),
    .frame_code_i    (frame_code),
    .rx_read_i       (rx_read_i),
    .rx_word_o       (rx_word_o),
    .rx_data_ready_o (rx_data_ready_o)
  );

endmodule

// File: tb_ps2_keyboard.sv
// testbench for the PS/2 keyboard interface with clock, reset, keyboard line model and stimulus table
`timescale 1ns/10ps

module tb_ps2_keyboard
  import ps2_pkg::*;
();

  localparam int LONG_CYCLES     = 100;
  localparam int DEBOUNCE_CYCLES = 6;
  // keyboard clock half period in system clocks
  localparam int KB_HALF         = 20;
  localparam int NUM_ENTRIES     = 10;
  // longer than the long timer, so the watchdog has fired
  localparam int WATCHDOG_IDLE   = 160;
  localparam int READY_TIMEOUT   = 50;
  localparam int ACK_TIMEOUT     = 20;
  localparam int HOLD_TIMEOUT    = 300;

  typedef enum logic [1:0] {KIND_RX, KIND_TX, KIND_PART} kind_e;

  typedef struct packed {
    kind_e      kind;
    scan_code_t code;
    logic       translate;
    logic       ack_en;
    logic       exp_released;
    logic       exp_ready;
    logic       exp_error;
  } entry_t;

  logic       clk = 1'b0;
  logic       reset;
  logic       translate;
  logic       rx_read;
  logic       tx_write;
  scan_code_t tx_data;
  logic       kb_clk;
  logic       kb_data;
  ps2_line_t  line;
  ps2_pad_t   pad;
  rx_word_t   rx_word;
  logic       rx_ready;
  logic       tx_write_ack;
  logic       tx_error;

  entry_t stim [NUM_ENTRIES];
  frame_t host_frame;
  logic   model_timeout;
  logic   error_before_idle;
  int     tx_err_start;
  int     ready_events = 0;
  int     error_cycles = 0;
  logic   ready_prev   = 1'b0;
  int     check_count  = 0;
  int     error_count  = 0;

  always #2 clk = ~clk;

  // each wire is the wired-AND of the keyboard drive and the host release control
  assign line = {kb_clk & pad.clk_hi_z, kb_data & pad.data_hi_z};

  ps2_keyboard #(
    .TIMER_LONG_CYCLES     (LONG_CYCLES),
    .TIMER_DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_dut (
    .clk             (clk),
    .reset           (reset),
    .ps2_line_i      (line),
    .ps2_pad_o       (pad),
    .translate_i     (translate),
    .rx_read_i       (rx_read),
    .rx_word_o       (rx_word),
    .rx_data_ready_o (rx_ready),
    .tx_data_i       (tx_data),
    .tx_write_i      (tx_write),
    .tx_write_ack_o  (tx_write_ack),
    .tx_error_o      (tx_error)
  );

  // counts ready rising edges and error cycles, sampled before the edge updates them
  always @(posedge clk)
  begin
    ready_prev <= rx_ready;
    if (rx_ready && !ready_prev)
      ready_events <= ready_events + 1;
    if (tx_error)
      error_cycles <= error_cycles + 1;
  end

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got == exp)
    else
    begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    error_count++;
  endtask

  // parity bit that makes the count of ones over data and parity odd
  function automatic logic odd_parity(input scan_code_t v);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += int'(v[i]);
    return ((ones % 2) == 0);
  endfunction

  function automatic string kind_text(input kind_e k);
    case (k)
      KIND_RX: return "receive";
      KIND_TX: return "transmit";
      default: return "partial";
    endcase
  endfunction

  // ------------------------------
  // keyboard line model
  // ------------------------------

  // data changes while the clock is high, the host samples on the falling edge
  task automatic send_frame(input scan_code_t code, input int nbits);
    frame_t bits;
    bits = {1'b1, odd_parity(code), code, 1'b0};
    for (int i = 0; i < nbits; i++)
    begin
      kb_data = bits[i];
      wait_cycles(KB_HALF);
      kb_clk = 1'b0;
      wait_cycles(KB_HALF);
      kb_clk = 1'b1;
    end
    wait_cycles(KB_HALF);
    kb_data = 1'b1;
  endtask

  // the host moves data after each rising edge, so each bit is read just before a fall
  task automatic receive_host_frame(input logic ack_en);
    int n;
    model_timeout = 1'b0;
    host_frame    = '0;
    n = 0;
    while (line.clk && n < HOLD_TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    n = 0;
    while (!line.clk && n < HOLD_TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (!line.clk || n == 0)
      model_timeout = 1'b1;
    else
    begin
      wait_cycles(KB_HALF);
      host_frame[0] = line.data;
      for (int k = 1; k < FRAME_BITS; k++)
      begin
        kb_clk = 1'b0;
        wait_cycles(KB_HALF);
        kb_clk = 1'b1;
        wait_cycles(KB_HALF);
        host_frame[k] = line.data;
      end
      // acknowledge is data held low across one more clock pulse
      if (ack_en)
        kb_data = 1'b0;
      wait_cycles(2);
      kb_clk = 1'b0;
      wait_cycles(KB_HALF);
      error_before_idle = (error_cycles != tx_err_start);
      kb_clk  = 1'b1;
      kb_data = 1'b1;
      wait_cycles(KB_HALF);
    end
  endtask

  // ------------------------------
  // host side and table entries
  // ------------------------------

  task automatic write_byte(input scan_code_t code, output logic ack_seen);
    int n;
    @(negedge clk);
    tx_data  = code;
    tx_write = 1'b1;
    #1;
    n = 0;
    while (!tx_write_ack && n < ACK_TIMEOUT)
    begin
      @(negedge clk);
      #1;
      n++;
    end
    ack_seen = tx_write_ack;
    @(negedge clk);
    tx_write = 1'b0;
  endtask

  task automatic run_receive(input entry_t e);
    int gap;
    int hold;
    int start;
    int n;
    translate = e.translate;
    gap = 5 + int'($urandom % 32'd20);
    wait_cycles(gap);
    start = ready_events;
    send_frame(e.code, (e.kind == KIND_PART) ? 4 : FRAME_BITS);
    if (e.kind == KIND_PART)
      wait_cycles(WATCHDOG_IDLE);
    if (!e.exp_ready)
    begin
      wait_cycles(10);
      check_hex("ready events", 32'(ready_events - start), 32'd0);
      check_hex("rx_data_ready_o", 32'(rx_ready), 32'd0);
    end
    else
    begin
      n = 0;
      while (!rx_ready && n < READY_TIMEOUT)
      begin
        @(negedge clk);
        n++;
      end
      if (!rx_ready)
        report_failure("rx_data_ready_o never rose after a full frame");
      else
      begin
        check_hex("rx_word_o.code", 32'(rx_word.code), 32'(e.code));
        check_hex("rx_word_o.released", 32'(rx_word.released), 32'(e.exp_released));
        // ready is a level and has to survive a slow host
        hold = int'($urandom % 32'd30);
        wait_cycles(hold);
        check_hex("rx_data_ready_o", 32'(rx_ready), 32'd1);
        rx_read = 1'b1;
        @(negedge clk);
        rx_read = 1'b0;
        n = 0;
        while (rx_ready && n < 3)
        begin
          @(negedge clk);
          n++;
        end
        if (rx_ready)
          report_failure("rx_data_ready_o stayed high after the read strobe");
        // the edge counter lags ready by a cycle, so it is read once the word is consumed
        check_hex("ready events", 32'(ready_events - start), 32'd1);
      end
    end
  endtask

  task automatic run_transmit(input entry_t e);
    int   start;
    int   n;
    logic ack_seen;
    ack_seen = 1'b0;
    wait_cycles(5 + int'($urandom % 32'd20));
    start             = ready_events;
    tx_err_start      = error_cycles;
    error_before_idle = 1'b0;
    fork
      write_byte(e.code, ack_seen);
      receive_host_frame(e.ack_en);
    join
    n = 0;
    while (tx_error && n < 20)
    begin
      @(negedge clk);
      n++;
    end
    if (tx_error)
      report_failure("tx_error_o stayed high after the lines went idle");
    wait_cycles(4);
    check_hex("tx_write_ack_o seen", 32'(ack_seen), 32'd1);
    if (model_timeout)
      report_failure("the keyboard model never saw the clock request from the host");
    else
    begin
      check_hex("ps2 data start bit", 32'(host_frame[0]), 32'd0);
      check_hex("ps2 data byte", 32'(host_frame[8:1]), 32'(e.code));
      check_hex("ps2 data parity bit", 32'(host_frame[9]), 32'(odd_parity(e.code)));
      check_hex("ps2 data stop bit", 32'(host_frame[10]), 32'd1);
      check_hex("tx_error_o before idle", 32'(error_before_idle), 32'(e.exp_error));
    end
    if (!e.exp_error)
      check_hex("tx_error_o cycles", 32'(error_cycles - tx_err_start), 32'd0);
    check_hex("ready events", 32'(ready_events - start), 32'd0);
  endtask

  // columns: kind, byte, translate, ack enable, released, ready event, error
  task automatic fill_stimulus_table();
    stim[0] = '{KIND_RX,   8'h1C, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
    stim[1] = '{KIND_RX,   8'hF0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
    stim[2] = '{KIND_RX,   8'h1C, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
    stim[3] = '{KIND_RX,   8'hF0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    stim[4] = '{KIND_TX,   8'hED, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    stim[5] = '{KIND_TX,   8'h55, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    stim[6] = '{KIND_PART, 8'h3A, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
    stim[7] = '{KIND_RX,   8'h2B, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    stim[8] = '{KIND_TX,   8'hF4, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    stim[9] = '{KIND_RX,   8'h5A, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial
  begin
    entry_t e;
    int     errors_before;
    reset     = 1'b1;
    translate = 1'b0;
    rx_read   = 1'b0;
    tx_write  = 1'b0;
    tx_data   = '0;
    kb_clk    = 1'b1;
    kb_data   = 1'b1;
    void'($urandom(32'h2f0b));
    fill_stimulus_table();
    repeat (5) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_hex("ps2_pad_o", 32'(pad), 32'h3);
    check_hex("rx_data_ready_o", 32'(rx_ready), 32'd0);
    check_hex("tx_error_o", 32'(tx_error), 32'd0);
    check_hex("rx_word_o", 32'(rx_word), 32'd0);
    $display("reset values: %s", (error_count == 0) ? "ok" : "mismatch");
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      e = stim[i];
      errors_before = error_count;
      if (e.kind == KIND_TX)
        run_transmit(e);
      else
        run_receive(e);
      $display("entry %0d %s %h: %s", i, kind_text(e.kind), e.code,
               (error_count == errors_before) ? "ok" : "mismatch");
    end
    $display("entries %0d, checks %0d, errors %0d", NUM_ENTRIES, check_count, error_count);
    if (error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // stops a run whose waits went wrong
  initial
  begin
    #200000;
    $display("the run reached its time limit before the table was done");
    $display("Test failed");
    $finish;
  end

endmodule

// File: build.f
ps2_pkg.sv
ps2_timer.sv
ps2_link_engine.sv
ps2_rx_decoder.sv
ps2_keyboard.sv
tb_ps2_keyboard.sv

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator and run, pass only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_ps2_keyboard -f build.f -o tb_ps2_keyboard \
  && ./obj_dir/tb_ps2_keyboard | tee /dev/stderr | grep -qx "Test passed" \
  && echo "simulation result: pass" \
  || { echo "simulation result: fail"; exit 1; }

exit 0
